//--- bench/mmr_stimulus.txt
# C byte | W1 addr dsn data | W2 addr dsn data old_value | R pulse (1 or 0)
# V pulses vblank | E output expected, all values in hex
V
E obj_base_sh 0000
E scr1_base_sh 0000
E hpos1_sh 0000
E vpos3_sh 0000
E prio0_sh ffff
E prio3_sh ffff
E pal_page_en_sh 3f
E layer_en 0
W2 14 0 1234 ffff
R 0
W1 06 0 a1b2
W1 06 1 ccdd
W1 07 0 1122
W1 07 2 3344
W1 08 3 ffff
V
E hpos1_sh ccb2
E vpos1_sh 1144
E hpos2_sh 0000
E prio0_sh 1234
W1 05 0 0a50
W1 05 0 0a55
R 1
R 0
V
E pal_base_sh 0a55
C 1f
C 1e
C 1b
C 1a
C 19
C 1c
W2 19 0 5678 1234
W2 14 0 9999 1234
W2 1f 0 0015 003f
W2 15 0 eeee 003f
V
E prio0_sh 5678
E prio1_sh ffff
E prio2_sh ffff
E pal_page_en_sh 15
W2 1c 0 06ca 0000
W1 11 0 8000
V
E layer_slot0 3
E layer_slot1 2
E layer_slot2 1
E layer_slot3 0
E layer_en 5
W1 11 0 0000
V
E layer_en 0
E layer_slot2 1
W1 06 0 4321
E hpos1_sh ccb2
R 0
E hpos1_sh ccb2
V
E hpos1_sh 4321

//--- bench/mmr_tb.sv
/*
 * Testbench for the video register block. Runs the operations listed in
 * bench/mmr_stimulus.txt on the CPU bus and checks write readback, the palette
 * copy pulse and the frame latch shadow outputs against the listed values.
 */
module mmr_tb;
    timeunit 1ns;
    timeprecision 1ps;

    typedef logic [8*16-1:0] token_t;

    // Cycles any handshake wait may take before it counts as lost
    localparam int WAIT_LIMIT = 8;

    logic                 clk;
    logic                 reg_rst;
    logic                 ppu1_cs;
    logic                 ppu2_cs;
    mmr_pkg::mmr_addr_t   addr;
    mmr_pkg::mmr_dsn_t    dsn;
    mmr_pkg::mmr_word_t   cpu_dout;
    logic                 cfg_we;
    logic [7:0]           cfg_data;
    logic                 vblank;
    mmr_pkg::mmr_word_t   mmr_dout;
    logic                 pal_copy;
    logic                 frame_load;
    mmr_pkg::mmr_word_t   obj_base_sh, scr1_base_sh, scr2_base_sh, scr3_base_sh;
    mmr_pkg::mmr_word_t   pal_base_sh, hpos1_sh, vpos1_sh, hpos2_sh, vpos2_sh;
    mmr_pkg::mmr_word_t   hpos3_sh, vpos3_sh, prio0_sh, prio1_sh, prio2_sh, prio3_sh;
    mmr_pkg::pal_pages_t  pal_page_en_sh;
    mmr_pkg::layer_slot_t layer_slot0, layer_slot1, layer_slot2, layer_slot3;
    logic [2:0]           layer_en;

    int                 errors;
    int                 fd;
    int                 code;
    token_t             op;
    token_t             name;
    logic [8*128-1:0]   rest;
    logic [7:0]         op_byte;
    mmr_pkg::mmr_addr_t op_addr;
    mmr_pkg::mmr_dsn_t  op_dsn;
    mmr_pkg::mmr_word_t op_data;
    mmr_pkg::mmr_word_t op_exp;

    mmr_top i_dut (
        .clk (clk), .reg_rst (reg_rst), .ppu1_cs (ppu1_cs), .ppu2_cs (ppu2_cs),
        .addr (addr), .dsn (dsn), .cpu_dout (cpu_dout), .cfg_we (cfg_we),
        .cfg_data (cfg_data), .vblank (vblank), .mmr_dout (mmr_dout),
        .pal_copy (pal_copy), .frame_load (frame_load),
        .obj_base_sh (obj_base_sh), .scr1_base_sh (scr1_base_sh),
        .scr2_base_sh (scr2_base_sh), .scr3_base_sh (scr3_base_sh),
        .pal_base_sh (pal_base_sh), .hpos1_sh (hpos1_sh), .vpos1_sh (vpos1_sh),
        .hpos2_sh (hpos2_sh), .vpos2_sh (vpos2_sh), .hpos3_sh (hpos3_sh),
        .vpos3_sh (vpos3_sh), .prio0_sh (prio0_sh), .prio1_sh (prio1_sh),
        .prio2_sh (prio2_sh), .prio3_sh (prio3_sh), .pal_page_en_sh (pal_page_en_sh),
        .layer_slot0 (layer_slot0), .layer_slot1 (layer_slot1),
        .layer_slot2 (layer_slot2), .layer_slot3 (layer_slot3), .layer_en (layer_en)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic check_word(input string sig, input mmr_pkg::mmr_word_t exp,
                              input mmr_pkg::mmr_word_t act);
        if (act !== exp) begin
            $display("CHECK FAILED time=%0t %s expected=%h actual=%h", $time, sig, exp, act);
            errors++;
        end
    endtask

    task automatic check_pages(input string sig, input mmr_pkg::pal_pages_t exp,
                               input mmr_pkg::pal_pages_t act);
        if (act !== exp) begin
            $display("CHECK FAILED time=%0t %s expected=%h actual=%h", $time, sig, exp, act);
            errors++;
        end
    endtask

    task automatic check_slot(input string sig, input mmr_pkg::layer_slot_t exp,
                              input mmr_pkg::layer_slot_t act);
        if (act !== exp) begin
            $display("CHECK FAILED time=%0t %s expected=%h actual=%h", $time, sig, exp, act);
            errors++;
        end
    endtask

    task automatic check_bit(input string sig, input logic exp, input logic act);
        if (act !== exp) begin
            $display("CHECK FAILED time=%0t %s expected=%b actual=%b", $time, sig, exp, act);
            errors++;
        end
    endtask

    // Outputs straight out of reset, before any vertical blank
    task automatic check_reset_state();
        check_word("scr2_base_sh", 16'h0000, scr2_base_sh);
        check_word("scr3_base_sh", 16'h0000, scr3_base_sh);
        check_word("vpos2_sh", 16'h0000, vpos2_sh);
        check_word("hpos3_sh", 16'h0000, hpos3_sh);
        check_word("mmr_dout", 16'h0000, mmr_dout);
        check_bit("pal_copy", 1'b0, pal_copy);
        check_bit("frame_load", 1'b0, frame_load);
    endtask

    // Outputs settle well before the drive point 10 ns after the edge
    task automatic next_cycle();
        @(posedge clk);
        #10;
    endtask

    task automatic write_fixed(input mmr_pkg::mmr_addr_t a, input mmr_pkg::mmr_dsn_t d,
                               input mmr_pkg::mmr_word_t w);
        ppu2_cs  = 1'b0;
        ppu1_cs  = 1'b1;
        addr     = a;
        dsn      = d;
        cpu_dout = w;
        next_cycle();
        check_bit("pal_copy", 1'b0, pal_copy);
    endtask

    task automatic write_cfg(input mmr_pkg::mmr_addr_t a, input mmr_pkg::mmr_dsn_t d,
                             input mmr_pkg::mmr_word_t w, input mmr_pkg::mmr_word_t old);
        ppu1_cs  = 1'b0;
        ppu2_cs  = 1'b1;
        addr     = a;
        dsn      = d;
        cpu_dout = w;
        next_cycle();
        ppu2_cs = 1'b0;
        check_word("mmr_dout", old, mmr_dout);
    endtask

    task automatic shift_cfg(input logic [7:0] b);
        ppu1_cs  = 1'b0;
        cfg_we   = 1'b1;
        cfg_data = b;
        next_cycle();
        cfg_we = 1'b0;
    endtask

    task automatic release_and_check_copy(input logic expect_pulse);
        int waited;
        waited  = 0;
        ppu1_cs = 1'b0;
        ppu2_cs = 1'b0;
        if (expect_pulse) begin
            next_cycle();
            while (pal_copy !== 1'b1 && waited < WAIT_LIMIT) begin
                next_cycle();
                waited++;
            end
            if (pal_copy !== 1'b1) begin
                $display("ERROR time=%0t: no pal_copy pulse after chip select release", $time);
                errors++;
            end else begin
                // The pulse lasts a single cycle
                next_cycle();
                check_bit("pal_copy", 1'b0, pal_copy);
            end
        end else begin
            for (int i = 0; i < 4; i++) begin
                next_cycle();
                check_bit("pal_copy", 1'b0, pal_copy);
            end
        end
    endtask

    task automatic pulse_vblank();
        int waited;
        int pulses;
        waited  = 0;
        pulses  = 0;
        ppu1_cs = 1'b0;
        ppu2_cs = 1'b0;
        vblank  = 1'b1;
        next_cycle();
        while (frame_load !== 1'b1 && waited < WAIT_LIMIT) begin
            next_cycle();
            waited++;
        end
        if (frame_load !== 1'b1) begin
            $display("ERROR time=%0t: frame_load never pulsed after vblank rose", $time);
            errors++;
        end else if (waited != 1) begin
            $display("ERROR time=%0t: shadow load came %0d clocks after vblank instead of 2",
                     $time, waited + 1);
            errors++;
        end
        // vblank stays high, no second load may follow
        for (int i = 0; i < 3; i++) begin
            next_cycle();
            if (frame_load === 1'b1) pulses++;
        end
        vblank = 1'b0;
        next_cycle();
        if (pulses != 0) begin
            $display("ERROR time=%0t: frame_load pulsed again while vblank stayed high", $time);
            errors++;
        end
    endtask

    task automatic check_output(input token_t sig, input mmr_pkg::mmr_word_t val);
        case (sig)
            token_t'("obj_base_sh"):    check_word("obj_base_sh", val, obj_base_sh);
            token_t'("scr1_base_sh"):   check_word("scr1_base_sh", val, scr1_base_sh);
            token_t'("scr2_base_sh"):   check_word("scr2_base_sh", val, scr2_base_sh);
            token_t'("scr3_base_sh"):   check_word("scr3_base_sh", val, scr3_base_sh);
            token_t'("pal_base_sh"):    check_word("pal_base_sh", val, pal_base_sh);
            token_t'("hpos1_sh"):       check_word("hpos1_sh", val, hpos1_sh);
            token_t'("vpos1_sh"):       check_word("vpos1_sh", val, vpos1_sh);
            token_t'("hpos2_sh"):       check_word("hpos2_sh", val, hpos2_sh);
            token_t'("vpos2_sh"):       check_word("vpos2_sh", val, vpos2_sh);
            token_t'("hpos3_sh"):       check_word("hpos3_sh", val, hpos3_sh);
            token_t'("vpos3_sh"):       check_word("vpos3_sh", val, vpos3_sh);
            token_t'("prio0_sh"):       check_word("prio0_sh", val, prio0_sh);
            token_t'("prio1_sh"):       check_word("prio1_sh", val, prio1_sh);
            token_t'("prio2_sh"):       check_word("prio2_sh", val, prio2_sh);
            token_t'("prio3_sh"):       check_word("prio3_sh", val, prio3_sh);
            token_t'("pal_page_en_sh"): check_pages("pal_page_en_sh", val[5:0], pal_page_en_sh);
            token_t'("layer_slot0"):    check_slot("layer_slot0", val[1:0], layer_slot0);
            token_t'("layer_slot1"):    check_slot("layer_slot1", val[1:0], layer_slot1);
            token_t'("layer_slot2"):    check_slot("layer_slot2", val[1:0], layer_slot2);
            token_t'("layer_slot3"):    check_slot("layer_slot3", val[1:0], layer_slot3);
            token_t'("layer_en"): begin
                check_bit("layer_en[0]", val[0], layer_en[0]);
                check_bit("layer_en[1]", val[1], layer_en[1]);
                check_bit("layer_en[2]", val[2], layer_en[2]);
            end
            default: begin
                $display("ERROR time=%0t: stimulus names an unknown output %0s", $time, sig);
                errors++;
            end
        endcase
    endtask

    initial begin
        errors   = 0;
        reg_rst  = 1'b1;
        ppu1_cs  = 1'b0;
        ppu2_cs  = 1'b0;
        addr     = '0;
        dsn      = 2'b11;
        cpu_dout = '0;
        cfg_we   = 1'b0;
        cfg_data = '0;
        vblank   = 1'b0;
        repeat (4) @(posedge clk);
        #10;
        reg_rst = 1'b0;
        check_reset_state();

        fd = $fopen("bench/mmr_stimulus.txt", "r");
        if (fd == 0) begin
            $display("ERROR: the stimulus file bench/mmr_stimulus.txt could not be opened");
            errors++;
        end else begin
            while ($feof(fd) == 0) begin
                op   = '0;
                code = $fscanf(fd, "%s", op);
                if (code != 1) break;
                if (op == token_t'("#")) begin
                    code = $fgets(rest, fd);
                end else if (op == token_t'("C")) begin
                    code = $fscanf(fd, "%h", op_byte);
                    shift_cfg(op_byte);
                end else if (op == token_t'("W1")) begin
                    code = $fscanf(fd, "%h %h %h", op_addr, op_dsn, op_data);
                    write_fixed(op_addr, op_dsn, op_data);
                end else if (op == token_t'("W2")) begin
                    code = $fscanf(fd, "%h %h %h %h", op_addr, op_dsn, op_data, op_exp);
                    write_cfg(op_addr, op_dsn, op_data, op_exp);
                end else if (op == token_t'("R")) begin
                    code = $fscanf(fd, "%h", op_byte);
                    release_and_check_copy(op_byte[0]);
                end else if (op == token_t'("V")) begin
                    pulse_vblank();
                end else if (op == token_t'("E")) begin
                    name = '0;
                    code = $fscanf(fd, "%s %h", name, op_exp);
                    check_output(name, op_exp);
                end else begin
                    $display("ERROR time=%0t: unknown stimulus operation %0s", $time, op);
                    errors++;
                end
            end
            $fclose(fd);
        end

        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- build.f
src/mmr_pkg.sv
src/mmr_fixed_bank.sv
src/mmr_cfg_bank.sv
src/mmr_frame_latch.sv
src/mmr_top.sv
bench/mmr_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the register block testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module mmr_tb -f build.f --Mdir obj_dir -o mmr_sim

sim_out=$(./obj_dir/mmr_sim)
echo "$sim_out"

if echo "$sim_out" | grep -qx "TEST RESULT: PASS"; then
    exit 0
fi
exit 1

//--- src/mmr_cfg_bank.sv
/*
 * Register bank on the ppu2 chip select whose addresses come from a byte-wide
 * configuration shift register. A write returns the register's old value.
 */
module mmr_cfg_bank #(
    parameter int CFG_DEPTH = 16
) (
    input  logic                clk,
    input  logic                reg_rst,
    input  logic                ppu2_cs,
    input  mmr_pkg::mmr_addr_t  addr,
    input  mmr_pkg::mmr_dsn_t   dsn,
    input  mmr_pkg::mmr_word_t  cpu_dout,
    input  logic                cfg_we,
    input  logic [7:0]          cfg_data,
    output mmr_pkg::mmr_word_t  layer_ctrl,
    output mmr_pkg::mmr_word_t  prio0,
    output mmr_pkg::mmr_word_t  prio1,
    output mmr_pkg::mmr_word_t  prio2,
    output mmr_pkg::mmr_word_t  prio3,
    output mmr_pkg::pal_pages_t pal_page_en,
    output mmr_pkg::mmr_word_t  mmr_dout
);

    logic [CFG_DEPTH-1:0][7:0] cfg_sr;
    logic [5:0]                hit;
    logic                      hit_one;
    mmr_pkg::mmr_word_t        old_word;
    mmr_pkg::mmr_word_t        merged;

    // Configuration bytes, byte 0 is the newest
    always_ff @(posedge clk or posedge reg_rst) begin
        if (reg_rst) begin
            for (int i = 0; i < CFG_DEPTH; i++) begin
                cfg_sr[i] <= (i < 6) ? 8'(8'h13 + i) : 8'h00;
            end
        end else if (cfg_we) begin
            cfg_sr <= {cfg_sr[CFG_DEPTH-2:0], cfg_data};
        end
    end

    // Slot 0 is layer_ctrl, slot 5 the palette pages
    always_comb begin
        for (int i = 0; i < 6; i++) begin
            hit[i] = (addr == cfg_sr[i][4:0]);
        end
        hit_one = 1'b1;
        case (hit)
            6'b000001: old_word = layer_ctrl;
            6'b000010: old_word = prio0;
            6'b000100: old_word = prio1;
            6'b001000: old_word = prio2;
            6'b010000: old_word = prio3;
            6'b100000: old_word = {10'd0, pal_page_en};
            default: begin
                // No match, or an address claimed by two slots
                old_word = '0;
                hit_one  = 1'b0;
            end
        endcase
        merged = mmr_pkg::lane_merge(old_word, cpu_dout, dsn);
    end

    always_ff @(posedge clk or posedge reg_rst) begin
        if (reg_rst) begin
            layer_ctrl  <= '0;
            prio0       <= '1;
            prio1       <= '1;
            prio2       <= '1;
            prio3       <= '1;
            pal_page_en <= '1;
            mmr_dout    <= '0;
        end else if (ppu2_cs && hit_one) begin
            mmr_dout <= old_word;
            case (hit)
                6'b000001: layer_ctrl  <= merged;
                6'b000010: prio0       <= merged;
                6'b000100: prio1       <= merged;
                6'b001000: prio2       <= merged;
                6'b010000: prio3       <= merged;
                6'b100000: pal_page_en <= merged[5:0];
                default: ;
            endcase
        end
    end

endmodule

//--- src/mmr_fixed_bank.sv
/*
 * Fixed address register bank on the ppu1 chip select.
 * Holds the VRAM bases, scroll positions, palette base and PPU control, and
 * raises the palette copy request once the CPU releases the chip select.
 */
module mmr_fixed_bank (
    input  logic              clk,
    input  logic              reg_rst,
    input  logic              ppu1_cs,
    input  mmr_pkg::mmr_addr_t addr,
    input  mmr_pkg::mmr_dsn_t  dsn,
    input  mmr_pkg::mmr_word_t cpu_dout,
    output mmr_pkg::mmr_word_t obj_base,
    output mmr_pkg::mmr_word_t scr1_base,
    output mmr_pkg::mmr_word_t scr2_base,
    output mmr_pkg::mmr_word_t scr3_base,
    output mmr_pkg::mmr_word_t pal_base,
    output mmr_pkg::mmr_word_t hpos1,
    output mmr_pkg::mmr_word_t vpos1,
    output mmr_pkg::mmr_word_t hpos2,
    output mmr_pkg::mmr_word_t vpos2,
    output mmr_pkg::mmr_word_t hpos3,
    output mmr_pkg::mmr_word_t vpos3,
    output mmr_pkg::mmr_word_t ppu_ctrl,
    output logic              pal_copy
);

    mmr_pkg::mmr_word_t cur_word;
    mmr_pkg::mmr_word_t merged;
    logic               copy_pend;

    // Current value of the addressed register
    always_comb begin
        case (addr)
            mmr_pkg::REG_OBJ_BASE:  cur_word = obj_base;
            mmr_pkg::REG_SCR1_BASE: cur_word = scr1_base;
            mmr_pkg::REG_SCR2_BASE: cur_word = scr2_base;
            mmr_pkg::REG_SCR3_BASE: cur_word = scr3_base;
            mmr_pkg::REG_PAL_BASE:  cur_word = pal_base;
            mmr_pkg::REG_HPOS1:     cur_word = hpos1;
            mmr_pkg::REG_VPOS1:     cur_word = vpos1;
            mmr_pkg::REG_HPOS2:     cur_word = hpos2;
            mmr_pkg::REG_VPOS2:     cur_word = vpos2;
            mmr_pkg::REG_HPOS3:     cur_word = hpos3;
            mmr_pkg::REG_VPOS3:     cur_word = vpos3;
            mmr_pkg::REG_PPU_CTRL:  cur_word = ppu_ctrl;
            default:                cur_word = '0;
        endcase
        merged = mmr_pkg::lane_merge(cur_word, cpu_dout, dsn);
    end

    always_ff @(posedge clk or posedge reg_rst) begin
        if (reg_rst) begin
            obj_base  <= '0;
            scr1_base <= '0;
            scr2_base <= '0;
            scr3_base <= '0;
            pal_base  <= '0;
            hpos1     <= '0;
            vpos1     <= '0;
            hpos2     <= '0;
            vpos2     <= '0;
            hpos3     <= '0;
            vpos3     <= '0;
            ppu_ctrl  <= '0;
            copy_pend <= 1'b0;
            pal_copy  <= 1'b0;
        end else begin
            // pal_base is only stable after cs drops, so the copy waits for it
            pal_copy <= 1'b0;
            if (!ppu1_cs && copy_pend) begin
                pal_copy  <= 1'b1;
                copy_pend <= 1'b0;
            end
            if (ppu1_cs) begin
                case (addr)
                    mmr_pkg::REG_OBJ_BASE:  obj_base  <= merged;
                    mmr_pkg::REG_SCR1_BASE: scr1_base <= merged;
                    mmr_pkg::REG_SCR2_BASE: scr2_base <= merged;
                    mmr_pkg::REG_SCR3_BASE: scr3_base <= merged;
                    mmr_pkg::REG_PAL_BASE: begin
                        pal_base  <= merged;
                        copy_pend <= 1'b1;
                    end
                    mmr_pkg::REG_HPOS1:     hpos1     <= merged;
                    mmr_pkg::REG_VPOS1:     vpos1     <= merged;
                    mmr_pkg::REG_HPOS2:     hpos2     <= merged;
                    mmr_pkg::REG_VPOS2:     vpos2     <= merged;
                    mmr_pkg::REG_HPOS3:     hpos3     <= merged;
                    mmr_pkg::REG_VPOS3:     vpos3     <= merged;
                    mmr_pkg::REG_PPU_CTRL:  ppu_ctrl  <= merged;
                    default: ;
                endcase
            end
        end
    end

endmodule

//--- src/mmr_frame_latch.sv
/*
 * Copies both register banks into shadow registers at the start of vertical
 * blank and decodes the layer draw order and layer enables for the renderer.
 */
module mmr_frame_latch (
    input  logic                 clk,
    input  logic                 reg_rst,
    input  logic                 vblank,
    input  mmr_pkg::mmr_word_t   obj_base,
    input  mmr_pkg::mmr_word_t   scr1_base,
    input  mmr_pkg::mmr_word_t   scr2_base,
    input  mmr_pkg::mmr_word_t   scr3_base,
    input  mmr_pkg::mmr_word_t   pal_base,
    input  mmr_pkg::mmr_word_t   hpos1,
    input  mmr_pkg::mmr_word_t   vpos1,
    input  mmr_pkg::mmr_word_t   hpos2,
    input  mmr_pkg::mmr_word_t   vpos2,
    input  mmr_pkg::mmr_word_t   hpos3,
    input  mmr_pkg::mmr_word_t   vpos3,
    input  mmr_pkg::mmr_word_t   ppu_ctrl,
    input  mmr_pkg::mmr_word_t   layer_ctrl,
    input  mmr_pkg::mmr_word_t   prio0,
    input  mmr_pkg::mmr_word_t   prio1,
    input  mmr_pkg::mmr_word_t   prio2,
    input  mmr_pkg::mmr_word_t   prio3,
    input  mmr_pkg::pal_pages_t  pal_page_en,
    output mmr_pkg::mmr_word_t   obj_base_sh,
    output mmr_pkg::mmr_word_t   scr1_base_sh,
    output mmr_pkg::mmr_word_t   scr2_base_sh,
    output mmr_pkg::mmr_word_t   scr3_base_sh,
    output mmr_pkg::mmr_word_t   pal_base_sh,
    output mmr_pkg::mmr_word_t   hpos1_sh,
    output mmr_pkg::mmr_word_t   vpos1_sh,
    output mmr_pkg::mmr_word_t   hpos2_sh,
    output mmr_pkg::mmr_word_t   vpos2_sh,
    output mmr_pkg::mmr_word_t   hpos3_sh,
    output mmr_pkg::mmr_word_t   vpos3_sh,
    output mmr_pkg::mmr_word_t   prio0_sh,
    output mmr_pkg::mmr_word_t   prio1_sh,
    output mmr_pkg::mmr_word_t   prio2_sh,
    output mmr_pkg::mmr_word_t   prio3_sh,
    output mmr_pkg::pal_pages_t  pal_page_en_sh,
    output mmr_pkg::layer_slot_t layer_slot0,
    output mmr_pkg::layer_slot_t layer_slot1,
    output mmr_pkg::layer_slot_t layer_slot2,
    output mmr_pkg::layer_slot_t layer_slot3,
    output logic [2:0]           layer_en,
    output logic                 frame_load
);

    logic               vblank_q;
    logic               vblank_qq;
    mmr_pkg::mmr_word_t layer_ctrl_sh;
    logic               disp_en_sh;

    always_ff @(posedge clk or posedge reg_rst) begin
        if (reg_rst) begin
            vblank_q       <= 1'b0;
            vblank_qq      <= 1'b0;
            frame_load     <= 1'b0;
            obj_base_sh    <= '0;
            scr1_base_sh   <= '0;
            scr2_base_sh   <= '0;
            scr3_base_sh   <= '0;
            pal_base_sh    <= '0;
            hpos1_sh       <= '0;
            vpos1_sh       <= '0;
            hpos2_sh       <= '0;
            vpos2_sh       <= '0;
            hpos3_sh       <= '0;
            vpos3_sh       <= '0;
            prio0_sh       <= '1;
            prio1_sh       <= '1;
            prio2_sh       <= '1;
            prio3_sh       <= '1;
            pal_page_en_sh <= '1;
            layer_ctrl_sh  <= '0;
            disp_en_sh     <= 1'b0;
        end else begin
            vblank_q   <= vblank;
            vblank_qq  <= vblank_q;
            frame_load <= vblank_q && !vblank_qq;
            // One edge after vblank is first seen high
            if (vblank_q && !vblank_qq) begin
                obj_base_sh    <= obj_base;
                scr1_base_sh   <= scr1_base;
                scr2_base_sh   <= scr2_base;
                scr3_base_sh   <= scr3_base;
                pal_base_sh    <= pal_base;
                hpos1_sh       <= hpos1;
                vpos1_sh       <= vpos1;
                hpos2_sh       <= hpos2;
                vpos2_sh       <= vpos2;
                hpos3_sh       <= hpos3;
                vpos3_sh       <= vpos3;
                prio0_sh       <= prio0;
                prio1_sh       <= prio1;
                prio2_sh       <= prio2;
                prio3_sh       <= prio3;
                pal_page_en_sh <= pal_page_en;
                layer_ctrl_sh  <= layer_ctrl;
                disp_en_sh     <= ppu_ctrl[15];
            end
        end
    end

    // Draw order from the latched layer control
    assign layer_slot0 = layer_ctrl_sh[7:6];
    assign layer_slot1 = layer_ctrl_sh[9:8];
    assign layer_slot2 = layer_ctrl_sh[11:10];
    assign layer_slot3 = layer_ctrl_sh[13:12];

    // Master display enable blanks all layers
    assign layer_en = disp_en_sh ? layer_ctrl_sh[3:1] : 3'b000;

endmodule

//--- src/mmr_pkg.sv
/*
 * Shared types, fixed register map and lane merge for the video register block.
 * Every design file refers to these as mmr_pkg::name.
 */
package mmr_pkg;

    typedef logic [15:0] mmr_word_t;
    typedef logic [4:0]  mmr_addr_t;
    // Active low, bit 1 is the upper byte
    typedef logic [1:0]  mmr_dsn_t;
    typedef logic [5:0]  pal_pages_t;
    typedef logic [1:0]  layer_slot_t;

    // Word addresses of the fixed bank
    localparam mmr_addr_t REG_OBJ_BASE  = 5'h00;
    localparam mmr_addr_t REG_SCR1_BASE = 5'h01;
    localparam mmr_addr_t REG_SCR2_BASE = 5'h02;
    localparam mmr_addr_t REG_SCR3_BASE = 5'h03;
    localparam mmr_addr_t REG_PAL_BASE  = 5'h05;
    localparam mmr_addr_t REG_HPOS1     = 5'h06;
    localparam mmr_addr_t REG_VPOS1     = 5'h07;
    localparam mmr_addr_t REG_HPOS2     = 5'h08;
    localparam mmr_addr_t REG_VPOS2     = 5'h09;
    localparam mmr_addr_t REG_HPOS3     = 5'h0a;
    localparam mmr_addr_t REG_VPOS3     = 5'h0b;
    localparam mmr_addr_t REG_PPU_CTRL  = 5'h11;

    // A deselected lane keeps its old byte
    function automatic mmr_word_t lane_merge(input mmr_word_t old_word,
                                             input mmr_word_t new_word,
                                             input mmr_dsn_t  dsn);
        lane_merge[15:8] = dsn[1] ? old_word[15:8] : new_word[15:8];
        lane_merge[7:0]  = dsn[0] ? old_word[7:0]  : new_word[7:0];
    endfunction

endpackage

//--- src/mmr_top.sv
/*
 * Top level of the video register block: fixed bank, configurable bank
 * and the vertical blank frame latch that feeds the renderer.
 */
module mmr_top (
    input  logic                 clk,
    input  logic                 reg_rst,
    input  logic                 ppu1_cs,
    input  logic                 ppu2_cs,
    input  mmr_pkg::mmr_addr_t   addr,
    input  mmr_pkg::mmr_dsn_t    dsn,
    input  mmr_pkg::mmr_word_t   cpu_dout,
    input  logic                 cfg_we,
    input  logic [7:0]           cfg_data,
    input  logic                 vblank,
    output mmr_pkg::mmr_word_t   mmr_dout,
    output logic                 pal_copy,
    output logic                 frame_load,
    output mmr_pkg::mmr_word_t   obj_base_sh,
    output mmr_pkg::mmr_word_t   scr1_base_sh,
    output mmr_pkg::mmr_word_t   scr2_base_sh,
    output mmr_pkg::mmr_word_t   scr3_base_sh,
    output mmr_pkg::mmr_word_t   pal_base_sh,
    output mmr_pkg::mmr_word_t   hpos1_sh,
    output mmr_pkg::mmr_word_t   vpos1_sh,
    output mmr_pkg::mmr_word_t   hpos2_sh,
    output mmr_pkg::mmr_word_t   vpos2_sh,
    output mmr_pkg::mmr_word_t   hpos3_sh,
    output mmr_pkg::mmr_word_t   vpos3_sh,
    output mmr_pkg::mmr_word_t   prio0_sh,
    output mmr_pkg::mmr_word_t   prio1_sh,
    output mmr_pkg::mmr_word_t   prio2_sh,
    output mmr_pkg::mmr_word_t   prio3_sh,
    output mmr_pkg::pal_pages_t  pal_page_en_sh,
    output mmr_pkg::layer_slot_t layer_slot0,
    output mmr_pkg::layer_slot_t layer_slot1,
    output mmr_pkg::layer_slot_t layer_slot2,
    output mmr_pkg::layer_slot_t layer_slot3,
    output logic [2:0]           layer_en
);

    // Bytes in the address configuration chain
    localparam int CFG_DEPTH = 16;

    mmr_pkg::mmr_word_t  obj_base, scr1_base, scr2_base, scr3_base, pal_base;
    mmr_pkg::mmr_word_t  hpos1, vpos1, hpos2, vpos2, hpos3, vpos3, ppu_ctrl;
    mmr_pkg::mmr_word_t  layer_ctrl, prio0, prio1, prio2, prio3;
    mmr_pkg::pal_pages_t pal_page_en;

    mmr_fixed_bank u_fixed (
        .clk       (clk),
        .reg_rst   (reg_rst),
        .ppu1_cs   (ppu1_cs),
        .addr      (addr),
        .dsn       (dsn),
        .cpu_dout  (cpu_dout),
        .obj_base  (obj_base),
        .scr1_base (scr1_base),
        .scr2_base (scr2_base),
        .scr3_base (scr3_base),
        .pal_base  (pal_base),
        .hpos1     (hpos1),
        .vpos1     (vpos1),
        .hpos2     (hpos2),
        .vpos2     (vpos2),
        .hpos3     (hpos3),
        .vpos3     (vpos3),
        .ppu_ctrl  (ppu_ctrl),
        .pal_copy  (pal_copy)
    );

    mmr_cfg_bank #(
        .CFG_DEPTH (CFG_DEPTH)
    ) u_cfg (
        .clk         (clk),
        .reg_rst     (reg_rst),
        .ppu2_cs     (ppu2_cs),
        .addr        (addr),
        .dsn         (dsn),
        .cpu_dout    (cpu_dout),
        .cfg_we      (cfg_we),
        .cfg_data    (cfg_data),
        .layer_ctrl  (layer_ctrl),
        .prio0       (prio0),
        .prio1       (prio1),
        .prio2       (prio2),
        .prio3       (prio3),
        .pal_page_en (pal_page_en),
        .mmr_dout    (mmr_dout)
    );

    mmr_frame_latch u_latch (
        .clk            (clk),
        .reg_rst        (reg_rst),
        .vblank         (vblank),
        .obj_base       (obj_base),
        .scr1_base      (scr1_base),
        .scr2_base      (scr2_base),
        .scr3_base      (scr3_base),
        .pal_base       (pal_base),
        .hpos1          (hpos1),
        .vpos1          (vpos1),
        .hpos2          (hpos2),
        .vpos2          (vpos2),
        .hpos3          (hpos3),
        .vpos3          (vpos3),
        .ppu_ctrl       (ppu_ctrl),
        .layer_ctrl     (layer_ctrl),
        .prio0          (prio0),
        .prio1          (prio1),
        .prio2          (prio2),
        .prio3          (prio3),
        .pal_page_en    (pal_page_en),
        .obj_base_sh    (obj_base_sh),
        .scr1_base_sh   (scr1_base_sh),
        .scr2_base_sh   (scr2_base_sh),
        .scr3_base_sh   (scr3_base_sh),
        .pal_base_sh    (pal_base_sh),
        .hpos1_sh       (hpos1_sh),
        .vpos1_sh       (vpos1_sh),
        .hpos2_sh       (hpos2_sh),
        .vpos2_sh       (vpos2_sh),
        .hpos3_sh       (hpos3_sh),
        .vpos3_sh       (vpos3_sh),
        .prio0_sh       (prio0_sh),
        .prio1_sh       (prio1_sh),
        .prio2_sh       (prio2_sh),
        .prio3_sh       (prio3_sh),
        .pal_page_en_sh (pal_page_en_sh),
        .layer_slot0    (layer_slot0),
        .layer_slot1    (layer_slot1),
        .layer_slot2    (layer_slot2),
        .layer_slot3    (layer_slot3),
        .layer_en       (layer_en),
        .frame_load     (frame_load)
    );

endmodule
